// File: files.f
hdl/ctlPkg.sv
hdl/microDecode.sv
hdl/regControl.sv
hdl/diagDecode.sv
hdl/diagStatus.sv
hdl/ctlTop.sv
bench/clockGen.sv
bench/ctlBench.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ctlBench
FLAGS     ?= -j 0
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f files.f

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f files.f

clean:
	rm -rf $(OBJDIR)

// File: bench/ctlBench.sv
module ctlBench;
  timeunit 1ns;
  timeprecision 100ps;
  import ctlPkg::*;

  localparam logic [1:0] chkCtl  = 2'd0;
  localparam logic [1:0] chkDiag = 2'd1;
  localparam logic [1:0] chkAll  = 2'd2;

  typedef struct packed {
    cramWordT   cram;
    ebusInT     ebus;
    logic       condEn, condDiagFunc, aprClk, respMbox, respSim, conFmXfer;
    logic       mclLoadAr, mclLoadArx, mclMemArlInd, mcl18BitEa, mcl23BitEa, arx18;
    logic [1:0] checkSel;
  } rowT;

  logic     clk, arstN;
  cramWordT cram;
  ebusInT   ebusIn;
  logic     condEn, condDiagFunc, aprClk, respMbox, respSim, conFmXfer;
  logic     mclLoadAr, mclLoadArx, mclMemArlInd, mcl18BitEa, mcl23BitEa, arx18;
  arCtlT    arCtl;
  arxCtlT   arxCtl;
  mqCtlT    mqCtl;
  diagFuncT diagFunc;
  diagRegT  diagReg;
  ebusOutT  ebusOut;

  rowT      rows[$];
  logic     tableReady = 1'b0;
  int       errors = 0;
  int       checks = 0;

  clockGen clkGen (.clk(clk), .arstN(arstN));

  ctlTop dut (
    .CTL_DIAG_LD_FUNC_076(clk), .arstN(arstN), .cram(cram), .ebusIn(ebusIn),
    .condEn(condEn), .condDiagFunc(condDiagFunc), .aprClk(aprClk),
    .respMbox(respMbox), .respSim(respSim), .conFmXfer(conFmXfer),
    .mclLoadAr(mclLoadAr), .mclLoadArx(mclLoadArx), .mclMemArlInd(mclMemArlInd),
    .mcl18BitEa(mcl18BitEa), .mcl23BitEa(mcl23BitEa), .arx18(arx18),
    .arCtl(arCtl), .arxCtl(arxCtl), .mqCtl(mqCtl), .diagFunc(diagFunc),
    .diagReg(diagReg), .ebusOut(ebusOut)
  );

  // Expected outputs worked out from the control rules
  function automatic void predict(input rowT r, input diagRegT regNow, output arCtlT a,
                                  output arxCtlT x, output mqCtlT m, output diagFuncT f,
                                  output ebusOutT e);
    logic [0:2] c;
    logic       ind, regOn, resp, fmAr, fmArx, xd, arlClr, shift, mset;
    logic [0:4] rc;
    logic [0:6] code;
    logic       strobe, ld;
    logic [39:0] st;
    c      = r.condEn ? r.cram.cond : 3'd0;
    ind    = r.mclMemArlInd | (r.cram.spec == 5'o22) | (c == 3'd6);
    regOn  = (c == 3'd7);
    rc     = regOn ? {r.cram.magic[0:2], r.cram.magic[7:8]} : 5'd0;
    resp   = r.respMbox | r.respSim;
    fmAr   = r.conFmXfer & r.mclLoadAr;
    fmArx  = r.conFmXfer & r.mclLoadArx;
    // Diagnostic function source
    if (r.ebus.ds[0] | r.ebus.ds[1]) begin
      code   = r.ebus.ds;
      strobe = r.ebus.diagStrobe;
    end else begin
      code   = r.cram.magic[2:8];
      strobe = r.condDiagFunc & r.aprClk;
    end
    ld = code[0] & strobe;
    f.ld04x      = ld && code[1:3] == 3'o4;
    f.ld05x      = ld && code[1:3] == 3'o5;
    f.ld06x      = ld && code[1:3] == 3'o6;
    f.ld07x      = (ld && code[1:3] == 3'o7) ? 8'(1 << code[4:6]) : 8'd0;
    f.diagRead   = ld && code[1:3] == 3'o0;
    f.diagArLoad = code == 7'o177;
    xd = r.cram.ar[2] | f.diagArLoad;
    a.arlSel    = ind ? r.cram.magic[6:8] : r.cram.ar;
    a.arlSel[1] = a.arlSel[1] | f.diagArLoad | fmAr;
    a.arrSel[0] = (r.mclLoadAr | xd) & (xd | resp);
    a.arrSel[1] = r.cram.ar[1] | (r.cram.disp == 5'o02) | f.diagArLoad | fmAr;
    a.arrSel[2] = r.cram.ar[2];
    m.mqClr  = ind & r.cram.magic[2];
    x.arxClr = ind ? r.cram.magic[3] : (c == 3'd5);
    arlClr   = ind ? r.cram.magic[4] : (c == 3'd4);
    a.arrClr = ind ? r.cram.magic[5] : (c == 3'd4);
    a.ar12to17Clr = arlClr | r.mcl18BitEa | ((r.cram.disp == 5'o36) & r.arx18);
    a.ar00to11Clr = a.ar12to17Clr | r.mcl23BitEa;
    a.ar09to17Load = (c == 3'd2) | rc[1] | a.ar00to11Clr | (|a.arlSel);
    a.ar00to08Load = (c == 3'd1) | rc[0] | a.ar00to11Clr | (|a.arlSel) |
                     (r.cram.magic[0] & ind);
    a.arrLoad = rc[2] | r.cram.ar[2] | a.arrSel[1] | a.arrSel[0] | a.arrClr | (c == 3'd3);
    x.arxlSel[0] = (r.mclLoadArx | r.cram.arx[2]) & (r.cram.arx[2] | resp);
    x.arxlSel[1] = r.cram.arx[1] | fmArx;
    x.arxlSel[2] = r.cram.arx[2];
    x.arxrSel    = x.arxlSel;
    x.arxLoad    = r.cram.arx[0] | x.arxlSel[1] | x.arxlSel[2] | x.arxClr;
    shift = m.mqClr | rc[4] | (r.cram.spec == 5'o12) | (r.cram.disp == 5'o30) |
            (r.cram.disp == 5'o31);
    mset  = rc[3] | m.mqClr;
    m.mqmEn  = r.cram.mq;
    m.mqmSel = r.cram.mq ? {shift, mset} : 2'b00;
    m.mqSel  = r.cram.mq ? 2'b00 : {shift, mset};
    // Slice 0 of the readback sits at the top
    st = {a, x, m, regNow, 9'b0};
    st = st << (5 * code[4:6]);
    e  = f.diagRead ? {1'b1, st[39:35]} : 6'd0;
  endfunction

  function automatic rowT blankRow(input logic [1:0] sel);
    rowT r;
    r = '0;
    r.cram.magic = 9'($urandom);
    r.checkSel = sel;
    return r;
  endfunction

  task automatic buildTable();
    rowT r;
    for (int cc = 1; cc < 8; cc++) begin
      r = blankRow(chkCtl);
      r.cram.cond = 3'(cc);
      r.condEn = 1'b1;
      rows.push_back(r);
      r = blankRow(chkCtl);
      r.cram.cond = 3'(cc);
      rows.push_back(r);
    end
    r = blankRow(chkCtl);
    r.cram.spec = specArlInd;
    r.cram.ar = 3'($urandom);
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.mclMemArlInd = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.conFmXfer = 1'b1;
    r.mclLoadAr = 1'b1;
    r.mclLoadArx = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.mclLoadAr = 1'b1;
    r.mclLoadArx = 1'b1;
    r.respMbox = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.ar = 3'b001;
    r.cram.arx = 3'b001;
    r.respSim = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.ar = 3'b001;
    r.cram.arx = 3'b101;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.disp = dispAread;
    r.cram.arx = 3'b010;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.mcl18BitEa = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.mcl23BitEa = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.disp = dispEaMod;
    r.arx18 = 1'b1;
    rows.push_back(r);
    // MQ steering
    r = blankRow(chkCtl);
    r.cram.mq = 1'b1;
    r.cram.spec = specMqShift;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.spec = specMqShift;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.mq = 1'b1;
    r.cram.disp = dispMul;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.disp = dispDiv;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.mq = 1'b1;
    r.cram.cond = condRegCtl;
    r.condEn = 1'b1;
    rows.push_back(r);
    r = blankRow(chkCtl);
    r.cram.cond = condRegCtl;
    r.condEn = 1'b1;
    r.cram.magic = 9'o777;
    rows.push_back(r);
    // Diagnostic decode from console and magic sources
    for (int g = 4; g < 8; g++) begin
      r = blankRow(chkDiag);
      r.ebus.ds = 7'(8 * g + 64 + 2);
      r.ebus.diagStrobe = 1'b1;
      rows.push_back(r);
    end
    r = blankRow(chkDiag);
    r.ebus.ds = 7'o150;
    rows.push_back(r);
    r = blankRow(chkDiag);
    r.ebus.ds = 7'o177;
    rows.push_back(r);
    r = blankRow(chkAll);
    r.cram.magic[2:8] = 7'o177;
    rows.push_back(r);
    r = blankRow(chkDiag);
    r.cram.magic[2:8] = 7'o145;
    r.condDiagFunc = 1'b1;
    rows.push_back(r);
    r = blankRow(chkDiag);
    r.cram.magic[2:8] = 7'o145;
    r.condDiagFunc = 1'b1;
    r.aprClk = 1'b1;
    rows.push_back(r);
    // Function 076 write and readback of every slice
    r = blankRow(chkAll);
    r.ebus.ds = 7'o176;
    r.ebus.diagStrobe = 1'b1;
    r.ebus.data = 5'($urandom_range(31, 1));
    rows.push_back(r);
    for (int s = 0; s < 8; s++) begin
      r = blankRow(chkAll);
      r.ebus.ds = 7'(7'o100 + s);
      r.ebus.diagStrobe = 1'b1;
      r.cram.ar = 3'($urandom);
      r.cram.arx = 3'($urandom);
      r.cram.mq = 1'($urandom);
      r.ebus.data = 5'($urandom);
      rows.push_back(r);
    end
  endtask

  task automatic checkRow(input rowT r, input diagRegT regNow, input int idx);
    arCtlT    a;
    arxCtlT   x;
    mqCtlT    m;
    diagFuncT f;
    ebusOutT  e;
    predict(r, regNow, a, x, m, f, e);
    if (r.checkSel != chkDiag) begin
      checks += 3;
      assert (arCtl === a) else begin
        errors++;
        $display("** Error at %0t ns: row %0d arCtl %h, expected %h", $time, idx, arCtl, a);
      end
      assert (arxCtl === x) else begin
        errors++;
        $display("** Error at %0t ns: row %0d arxCtl %h, expected %h", $time, idx, arxCtl, x);
      end
      assert (mqCtl === m) else begin
        errors++;
        $display("** Error at %0t ns: row %0d mqCtl %h, expected %h", $time, idx, mqCtl, m);
      end
    end
    if (r.checkSel != chkCtl) begin
      checks += 3;
      assert (diagFunc === f) else begin
        errors++;
        $display("** Error at %0t ns: row %0d diagFunc %h, expected %h", $time, idx,
                 diagFunc, f);
      end
      assert (ebusOut === e) else begin
        errors++;
        $display("** Error at %0t ns: row %0d ebusOut %h, expected %h", $time, idx, ebusOut, e);
      end
      assert (diagReg === regNow) else begin
        errors++;
        $display("** Error at %0t ns: row %0d diagReg %h, expected %h", $time, idx,
                 diagReg, regNow);
      end
    end
  endtask

  initial begin
    diagRegT expReg;
    rowT     idleRow;
    void'($urandom(40));
    {cram, ebusIn, condEn, condDiagFunc, aprClk, respMbox, respSim, conFmXfer} = '0;
    {mclLoadAr, mclLoadArx, mclMemArlInd, mcl18BitEa, mcl23BitEa, arx18} = '0;
    buildTable();
    tableReady = 1'b1;
    expReg = '0;
    idleRow = '0;
    idleRow.checkSel = chkAll;
    wait (arstN === 1'b1);
    @(negedge clk);
    checkRow(idleRow, expReg, -1);
    foreach (rows[i]) begin
      @(posedge clk);
      cram <= rows[i].cram;
      ebusIn <= rows[i].ebus;
      {condEn, condDiagFunc, aprClk, respMbox, respSim, conFmXfer} <=
        {rows[i].condEn, rows[i].condDiagFunc, rows[i].aprClk, rows[i].respMbox,
         rows[i].respSim, rows[i].conFmXfer};
      {mclLoadAr, mclLoadArx, mclMemArlInd, mcl18BitEa, mcl23BitEa, arx18} <=
        {rows[i].mclLoadAr, rows[i].mclLoadArx, rows[i].mclMemArlInd,
         rows[i].mcl18BitEa, rows[i].mcl23BitEa, rows[i].arx18};
      @(negedge clk);
      checkRow(rows[i], expReg, i);
      // Register picks up the data on the coming edge
      if (rows[i].ebus.ds == 7'o176 && rows[i].ebus.diagStrobe) begin
        expReg = rows[i].ebus.data;
      end
    end
    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    wait (tableReady);
    #((rows.size() + 16 + 20) * 20);
    $display("Timeout: the test rows did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: bench/clockGen.sv
module clockGen (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk   = 1'b0;
    arstN = 1'b0;
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
  end

  always #10 clk = ~clk;

endmodule

// File: hdl/ctlTop.sv
module ctlTop (
  input  logic             CTL_DIAG_LD_FUNC_076,
  input  logic             arstN,
  input  ctlPkg::cramWordT cram,
  input  ctlPkg::ebusInT   ebusIn,
  input  logic             condEn,
  input  logic             condDiagFunc,
  input  logic             aprClk,
  input  logic             respMbox,
  input  logic             respSim,
  input  logic             conFmXfer,
  input  logic             mclLoadAr,
  input  logic             mclLoadArx,
  input  logic             mclMemArlInd,
  input  logic             mcl18BitEa,
  input  logic             mcl23BitEa,
  input  logic             arx18,
  output ctlPkg::arCtlT    arCtl,
  output ctlPkg::arxCtlT   arxCtl,
  output ctlPkg::mqCtlT    mqCtl,
  output ctlPkg::diagFuncT diagFunc,
  output ctlPkg::diagRegT  diagReg,
  output ctlPkg::ebusOutT  ebusOut
);
  import ctlPkg::*;

  decodeT     decode;
  logic [2:0] diagSel;

  microDecode uDecode (
    .cram         (cram),
    .condEn       (condEn),
    .mclMemArlInd (mclMemArlInd),
    .decode       (decode)
  );

  regControl uRegCtl (
    .cram       (cram),
    .decode     (decode),
    .diagArLoad (diagFunc.diagArLoad),
    .conFmXfer  (conFmXfer),
    .mclLoadAr  (mclLoadAr),
    .mclLoadArx (mclLoadArx),
    .respMbox   (respMbox),
    .respSim    (respSim),
    .mcl18BitEa (mcl18BitEa),
    .mcl23BitEa (mcl23BitEa),
    .arx18      (arx18),
    .arCtl      (arCtl),
    .arxCtl     (arxCtl),
    .mqCtl      (mqCtl)
  );

  // Function source is console ds or the microword magic field
  diagDecode uDiagDec (
    .ebusIn       (ebusIn),
    .cram         (cram),
    .condDiagFunc (condDiagFunc),
    .aprClk       (aprClk),
    .diagFunc     (diagFunc),
    .diagSel      (diagSel)
  );

  diagStatus uDiagStat (
    .CTL_DIAG_LD_FUNC_076 (CTL_DIAG_LD_FUNC_076),
    .arstN                (arstN),
    .ebusData             (ebusIn.data),
    .diagFunc             (diagFunc),
    .diagSel              (diagSel),
    .arCtl                (arCtl),
    .arxCtl               (arxCtl),
    .mqCtl                (mqCtl),
    .diagReg              (diagReg),
    .ebusOut              (ebusOut)
  );

endmodule

// File: hdl/diagStatus.sv
module diagStatus (
  input  logic             CTL_DIAG_LD_FUNC_076,
  input  logic             arstN,
  input  logic [0:4]       ebusData,
  input  ctlPkg::diagFuncT diagFunc,
  input  logic [2:0]       diagSel,
  input  ctlPkg::arCtlT    arCtl,
  input  ctlPkg::arxCtlT   arxCtl,
  input  ctlPkg::mqCtlT    mqCtl,
  output ctlPkg::diagRegT  diagReg,
  output ctlPkg::ebusOutT  ebusOut
);
  import ctlPkg::*;

  logic [0:statusWidth-1] status;
  logic                   loadReg;

  assign loadReg = diagFunc.ld07x[diagLd076];

  // Diagnostic control register written by function 076
  always_ff @(posedge CTL_DIAG_LD_FUNC_076 or negedge arstN) begin
    if (!arstN) begin
      diagReg <= '0;
    end else if (loadReg) begin
      diagReg <= diagRegT'(ebusData);
    end
  end

  // Slice 0 is the top five bits of the readback
  assign status = {arCtl, arxCtl, mqCtl, diagReg, 9'b0};

  always_comb begin
    if (diagFunc.diagRead) begin
      ebusOut.driving = 1'b1;
      ebusOut.data    = status[diagSel * 5 +: 5];
    end else begin
      ebusOut.driving = 1'b0;
      ebusOut.data    = '0;
    end
  end

endmodule

// File: hdl/diagDecode.sv
module diagDecode (
  input  ctlPkg::ebusInT   ebusIn,
  input  ctlPkg::cramWordT cram,
  input  logic             condDiagFunc,
  input  logic             aprClk,
  output ctlPkg::diagFuncT diagFunc,
  output logic [2:0]       diagSel
);
  import ctlPkg::*;

  logic       consoleCtl;
  logic [0:6] code;
  logic       strobe;
  logic       loadEn;
  logic [2:0] group;
  logic [2:0] sub;

  // Console owns the function code when either high ds bit is set
  assign consoleCtl = ebusIn.ds[0] | ebusIn.ds[1];

  always_comb begin
    if (consoleCtl) begin
      code   = ebusIn.ds;
      strobe = ebusIn.diagStrobe;
    end else begin
      code   = cram.magic[2:8];
      strobe = condDiagFunc & aprClk;
    end
  end

  assign group  = code[1:3];
  assign sub    = code[4:6];
  assign loadEn = code[0] & strobe;

  // Load groups
  always_comb begin
    diagFunc.ld04x = loadEn && (group == diagLoad04);
    diagFunc.ld05x = loadEn && (group == diagLoad05);
    diagFunc.ld06x = loadEn && (group == diagLoad06);
    if (loadEn && (group == diagLoad07)) begin
      diagFunc.ld07x = 8'b1 << sub;
    end else begin
      diagFunc.ld07x = 8'b0;
    end
  end

  // Read group 10x
  assign diagFunc.diagRead = loadEn && (group == diagRead10);

  // All ones code loads AR, level only
  assign diagFunc.diagArLoad = code[0] && (group == diagLoad07) && (sub == diagClkEdp);

  assign diagSel = sub;

endmodule

// File: hdl/regControl.sv
module regControl (
  input  ctlPkg::cramWordT cram,
  input  ctlPkg::decodeT   decode,
  input  logic             diagArLoad,
  input  logic             conFmXfer,
  input  logic             mclLoadAr,
  input  logic             mclLoadArx,
  input  logic             respMbox,
  input  logic             respSim,
  input  logic             mcl18BitEa,
  input  logic             mcl23BitEa,
  input  logic             arx18,
  output ctlPkg::arCtlT    arCtl,
  output ctlPkg::arxCtlT   arxCtl,
  output ctlPkg::mqCtlT    mqCtl
);
  import ctlPkg::*;

  logic       resp;
  logic       fmArLoad;
  logic       fmArxLoad;
  logic       arDiag;
  logic [0:2] arlMux;
  logic [0:2] arxSel;
  logic       arlClrBase;
  logic       shortEa;
  logic       leftLoad;
  logic       mqSet;
  logic       mqShiftTerm;

  assign resp      = respMbox | respSim;
  assign fmArLoad  = conFmXfer & mclLoadAr;
  assign fmArxLoad = conFmXfer & mclLoadArx;
  assign arDiag    = cram.ar[2] | diagArLoad;

  // Indirect AR left select comes from the magic field
  assign arlMux = decode.arlInd ? cram.magic[6:8] : cram.ar;

  always_comb begin
    arCtl.arlSel[0] = arlMux[0];
    arCtl.arlSel[1] = arlMux[1] | diagArLoad | fmArLoad;
    arCtl.arlSel[2] = arlMux[2];

    arCtl.arrSel[0] = (mclLoadAr | arDiag) & (arDiag | resp);
    arCtl.arrSel[1] = cram.ar[1] | decode.dispAread | diagArLoad | fmArLoad;
    arCtl.arrSel[2] = cram.ar[2];
  end

  // Clears, magic bits 2 to 5 take over under indirect
  always_comb begin
    if (decode.arlInd) begin
      mqCtl.mqClr   = cram.magic[2];
      arxCtl.arxClr = cram.magic[3];
      arlClrBase    = cram.magic[4];
      arCtl.arrClr  = cram.magic[5];
    end else begin
      mqCtl.mqClr   = 1'b0;
      arxCtl.arxClr = decode.condArxClr;
      arlClrBase    = decode.condArClr;
      arCtl.arrClr  = decode.condArClr;
    end
  end

  // Short EA clears the upper half address bits
  assign shortEa           = decode.dispEaMod & arx18;
  assign arCtl.ar12to17Clr = arlClrBase | mcl18BitEa | shortEa;
  assign arCtl.ar00to11Clr = arCtl.ar12to17Clr | mcl23BitEa;

  // AR loads
  assign leftLoad = arCtl.ar00to11Clr | (|arCtl.arlSel);

  always_comb begin
    arCtl.ar09to17Load = decode.condArlrLoad | decode.regCtl[1] | leftLoad;
    arCtl.ar00to08Load = decode.condArllLoad | decode.regCtl[0] | leftLoad |
                         (cram.magic[0] & decode.arlInd);
    arCtl.arrLoad      = decode.regCtl[2] | cram.ar[2] | arCtl.arrSel[1] |
                         arCtl.arrSel[0] | arCtl.arrClr | decode.condArrLoad;
  end

  // ARX left and right share one select
  always_comb begin
    arxSel[0] = (mclLoadArx | cram.arx[2]) & (cram.arx[2] | resp);
    arxSel[1] = cram.arx[1] | fmArxLoad;
    arxSel[2] = cram.arx[2];
  end

  assign arxCtl.arxlSel = arxSel;
  assign arxCtl.arxrSel = arxSel;
  assign arxCtl.arxLoad = cram.arx[0] | arxSel[1] | arxSel[2] | arxCtl.arxClr;

  // MQ and MQM steering
  assign mqSet       = decode.regCtl[3] | mqCtl.mqClr;
  assign mqShiftTerm = mqCtl.mqClr | decode.regCtl[4] | decode.specMqShift |
                       decode.dispMul | decode.dispDiv;

  always_comb begin
    mqCtl.mqmEn     = cram.mq;
    mqCtl.mqmSel[0] = cram.mq & mqShiftTerm;
    mqCtl.mqmSel[1] = cram.mq & mqSet;
    mqCtl.mqSel[0]  = ~cram.mq & mqShiftTerm;
    mqCtl.mqSel[1]  = ~cram.mq & mqSet;
  end

endmodule

// File: hdl/microDecode.sv
module microDecode (
  input  ctlPkg::cramWordT cram,
  input  logic             condEn,
  input  logic             mclMemArlInd,
  output ctlPkg::decodeT   decode
);
  import ctlPkg::*;

  logic specArlIndHit;
  logic condArlIndHit;
  logic condRegCtlHit;

  // Dispatch field
  always_comb begin
    decode.dispAread  = cram.disp == dispAread;
    decode.dispReturn = cram.disp == dispReturn;
    decode.dispNicond = cram.disp == dispNicond;
    decode.dispMul    = cram.disp == dispMul;
    decode.dispDiv    = cram.disp == dispDiv;
    decode.dispNorm   = cram.disp == dispNorm;
    decode.dispEaMod  = cram.disp == dispEaMod;
  end

  // Special field
  assign decode.specMqShift = cram.spec == specMqShift;
  assign specArlIndHit      = cram.spec == specArlInd;

  // Condition field, one-hot only while enabled
  always_comb begin
    decode.condArllLoad = condEn && (cram.cond == condArllLoad);
    decode.condArlrLoad = condEn && (cram.cond == condArlrLoad);
    decode.condArrLoad  = condEn && (cram.cond == condArrLoad);
    decode.condArClr    = condEn && (cram.cond == condArClr);
    decode.condArxClr   = condEn && (cram.cond == condArxClr);
    condArlIndHit       = condEn && (cram.cond == condArlInd);
    condRegCtlHit       = condEn && (cram.cond == condRegCtl);
  end

  assign decode.condArlInd = condArlIndHit;
  assign decode.condRegCtl = condRegCtlHit;

  // Memory, special or condition can each ask for indirect AR left
  assign decode.arlInd = mclMemArlInd | specArlIndHit | condArlIndHit;

  // Magic field register controls
  assign decode.regCtl = {cram.magic[0:2], cram.magic[7:8]} & {5{condRegCtlHit}};
  assign decode.arExp  = cram.magic[5] & condRegCtlHit;

endmodule

// File: hdl/ctlPkg.sv
package ctlPkg;

  // Dispatch field values
  localparam logic [4:0] dispAread  = 5'o02;
  localparam logic [4:0] dispReturn = 5'o03;
  localparam logic [4:0] dispNicond = 5'o06;
  localparam logic [4:0] dispMul    = 5'o30;
  localparam logic [4:0] dispDiv    = 5'o31;
  localparam logic [4:0] dispNorm   = 5'o35;
  localparam logic [4:0] dispEaMod  = 5'o36;

  // Special field values
  localparam logic [4:0] specMqShift = 5'o12;
  localparam logic [4:0] specArlInd  = 5'o22;

  // Condition field, bits 3 to 5
  localparam logic [2:0] condArllLoad = 3'd1;
  localparam logic [2:0] condArlrLoad = 3'd2;
  localparam logic [2:0] condArrLoad  = 3'd3;
  localparam logic [2:0] condArClr    = 3'd4;
  localparam logic [2:0] condArxClr   = 3'd5;
  localparam logic [2:0] condArlInd   = 3'd6;
  localparam logic [2:0] condRegCtl   = 3'd7;

  // Diagnostic function groups, ds bits 1 to 3
  localparam logic [2:0] diagLoad04 = 3'b100;
  localparam logic [2:0] diagLoad05 = 3'b101;
  localparam logic [2:0] diagLoad06 = 3'b110;
  localparam logic [2:0] diagLoad07 = 3'b111;
  localparam logic [2:0] diagRead10 = 3'b000;

  // Subfunctions within group 07
  localparam logic [2:0] diagLd076  = 3'd6;
  localparam logic [2:0] diagClkEdp = 3'd7;

  localparam int statusWidth = 40;

  typedef struct packed {
    logic [0:2] ar;
    logic [0:2] arx;
    logic       mq;
    logic [0:4] disp;
    logic [0:4] spec;
    logic [3:5] cond;
    logic [0:8] magic;
  } cramWordT;

  typedef struct packed {
    logic       dispAread;
    logic       dispReturn;
    logic       dispNicond;
    logic       dispMul;
    logic       dispDiv;
    logic       dispNorm;
    logic       dispEaMod;
    logic       specMqShift;
    logic       condArllLoad;
    logic       condArlrLoad;
    logic       condArrLoad;
    logic       condArClr;
    logic       condArxClr;
    logic       condArlInd;
    logic       condRegCtl;
    logic       arlInd;
    // Magic 0 to 2, then magic 7 to 8
    logic [0:4] regCtl;
    logic       arExp;
  } decodeT;

  typedef struct packed {
    logic [0:6]   ds;
    logic         diagStrobe;
    logic [24:28] data;
  } ebusInT;

  typedef struct packed {
    logic         driving;
    logic [24:28] data;
  } ebusOutT;

  typedef struct packed {
    logic       ar00to08Load;
    logic       ar09to17Load;
    logic       arrLoad;
    logic [0:2] arlSel;
    logic [0:2] arrSel;
    logic       ar00to11Clr;
    logic       ar12to17Clr;
    logic       arrClr;
  } arCtlT;

  typedef struct packed {
    logic       arxLoad;
    logic [0:2] arxlSel;
    logic [0:2] arxrSel;
    logic       arxClr;
  } arxCtlT;

  typedef struct packed {
    logic [0:1] mqSel;
    logic [0:1] mqmSel;
    logic       mqmEn;
    logic       mqClr;
  } mqCtlT;

  typedef struct packed {
    logic       ld04x;
    logic       ld05x;
    logic       ld06x;
    // One strobe per subfunction
    logic [7:0] ld07x;
    logic       diagRead;
    logic       diagArLoad;
  } diagFuncT;

  typedef struct packed {
    logic memReset;
    logic channelClkStop;
    logic ldEbusReg;
    logic forceExtend;
    logic diag4;
  } diagRegT;

endpackage
